//--- source/touch_pkg.sv
`default_nettype none

package touch_pkg;

	// Serial clock divider and frame layout
	typedef logic [4:0] div_t;
	typedef logic [4:0] tick_t;

	// cclk cycles per half period of touch_clk
	localparam div_t CLK_DIV_COUNT = 5'd25;

	// Frame positions, counted in touch_clk periods
	localparam tick_t FRAME_TICKS = 5'd24;
	localparam tick_t CMD_BITS = 5'd8;
	// Tick 8 is the converter busy slot and carries no data
	localparam tick_t RESP_START = 5'd9;
	localparam tick_t RESP_BITS = 5'd12;
	localparam tick_t RESP_LAST = RESP_START + RESP_BITS - 5'd1;
	localparam tick_t CSB_LOW_TICKS = 5'd22;

	// Hold after frame_done until the port has left its gap
	// frame_done comes early in tick 20 and the port idles at the end of tick 23
	typedef logic [7:0] guard_t;
	localparam guard_t GAP_GUARD =
		guard_t'(int'(FRAME_TICKS - RESP_LAST) * 2 * int'(CLK_DIV_COUNT));

	// Conversion result and averaging
	typedef logic [11:0] touch_val_t;
	localparam int SAMPLES_PER_AXIS = 16;
	localparam int AVG_SHIFT = $clog2(SAMPLES_PER_AXIS);
	// Wide enough for 16 full-scale readings
	localparam int ACC_W = $bits(touch_val_t) + AVG_SHIFT;
	typedef logic [ACC_W-1:0] acc_t;
	typedef logic [AVG_SHIFT-1:0] sample_cnt_t;
	localparam sample_cnt_t LAST_SAMPLE = sample_cnt_t'(SAMPLES_PER_AXIS - 1);

	// Panel calibration, offset first and then ceiling after the offset
	localparam touch_val_t X_ADJ_MIN = 12'h096;
	localparam touch_val_t X_POST_ADJ_MAX = 12'hF6E;
	localparam touch_val_t Y_ADJ_MIN = 12'h12C;
	localparam touch_val_t Y_POST_ADJ_MAX = 12'hED8;

	// Axis code, same value as command bits 2:1
	typedef enum logic [1:0] {
		DIM_X = 2'd1,
		DIM_Y = 2'd2,
		DIM_Z = 2'd3
	} touch_dim_e;

	typedef enum logic [1:0] {
		PS_IDLE,
		PS_FRAME,
		PS_GAP
	} port_state_e;

	typedef enum logic [1:0] {
		SQ_WAIT_BUSY,
		SQ_REQUEST,
		SQ_COLLECT
	} seq_state_e;

	typedef struct packed {
		touch_dim_e dim;
		touch_val_t value;
	} touch_sample_t;

	// Command byte: start bit, axis code, bit 3 set, upper nibble clear
	function automatic logic [7:0] make_cmd(touch_dim_e dim);
		logic [7:0] cmd;
		cmd = 8'b0000_1001;
		cmd[2:1] = dim;
		return cmd;
	endfunction

endpackage

`default_nettype wire

//--- source/touch_serial_port.sv
`timescale 1ns/10ps
`default_nettype none

module touch_serial_port (
	input wire cclk,
	input wire rstb,
	input wire frame_start,
	input wire touch_pkg::touch_dim_e frame_dim,
	input wire data_in,
	output logic touch_clk,
	output logic data_out,
	output logic touch_csb,
	output logic frame_done,
	output touch_pkg::touch_sample_t raw
);

	touch_pkg::port_state_e state;
	touch_pkg::div_t div_cnt;
	touch_pkg::tick_t tick;
	touch_pkg::touch_dim_e dim_q;

	// Command goes out LSB first from bit 0
	logic [7:0] cmd_sr;
	// Upper 11 response bits, the last bit joins them at capture
	logic [10:0] resp_sr;

	logic div_end;
	logic rise;
	logic fall;
	logic in_resp;
	logic resp_last;

	// Strobes fire in the cycle where touch_clk is about to toggle
	assign div_end = (div_cnt == touch_pkg::CLK_DIV_COUNT - 5'd1);
	assign rise = div_end && !touch_clk;
	assign fall = div_end && touch_clk;

	assign in_resp = (state == touch_pkg::PS_FRAME) &&
		(tick >= touch_pkg::RESP_START) && (tick <= touch_pkg::RESP_LAST);
	assign resp_last = rise && in_resp && (tick == touch_pkg::RESP_LAST);

	// Zeros shift in behind the command, so the pin rests low
	assign data_out = cmd_sr[0];

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= touch_pkg::PS_IDLE;
			div_cnt <= '0;
			tick <= '0;
			touch_clk <= 1'b0;
			touch_csb <= 1'b1;
			cmd_sr <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= resp_last;
			case (state)
				touch_pkg::PS_IDLE: begin
					div_cnt <= '0;
					tick <= '0;
					touch_clk <= 1'b0;
					if (frame_start) begin
						// First bit is on the pin before the first rising edge
						state <= touch_pkg::PS_FRAME;
						touch_csb <= 1'b0;
						cmd_sr <= touch_pkg::make_cmd(frame_dim);
					end
				end
				default: begin
					if (div_end) begin
						div_cnt <= '0;
						touch_clk <= ~touch_clk;
					end else begin
						div_cnt <= div_cnt + 5'd1;
					end

					// Tick boundary on the falling edge
					if (fall) begin
						tick <= tick + 5'd1;
						if (tick < touch_pkg::CMD_BITS) begin
							cmd_sr <= cmd_sr >> 1;
						end
						if (state == touch_pkg::PS_FRAME &&
								tick == touch_pkg::CSB_LOW_TICKS - 5'd1) begin
							touch_csb <= 1'b1;
							state <= touch_pkg::PS_GAP;
						end
						if (state == touch_pkg::PS_GAP &&
								tick == touch_pkg::FRAME_TICKS - 5'd1) begin
							state <= touch_pkg::PS_IDLE;
						end
					end
				end
			endcase
		end
	end

	// Response shift register and captured result
	always_ff @(posedge cclk) begin
		if (state == touch_pkg::PS_IDLE && frame_start) begin
			dim_q <= frame_dim;
		end
		// MSB arrives first
		if (rise && in_resp) begin
			resp_sr <= {resp_sr[9:0], data_in};
		end
		if (resp_last) begin
			raw.dim <= dim_q;
			raw.value <= {resp_sr, data_in};
		end
	end

endmodule

`default_nettype wire

//--- source/touch_scan_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module touch_scan_sequencer (
	input wire cclk,
	input wire rstb,
	input wire touch_busy,
	input wire frame_done,
	input wire touch_pkg::touch_sample_t raw,
	output logic frame_start,
	output touch_pkg::touch_dim_e frame_dim,
	output logic avg_valid,
	output touch_pkg::touch_sample_t avg
);

	touch_pkg::seq_state_e state;
	touch_pkg::touch_dim_e dim;
	touch_pkg::acc_t acc;
	touch_pkg::acc_t sum;
	touch_pkg::sample_cnt_t count;
	touch_pkg::guard_t guard;
	logic last_sample;

	// Running total including the reading that just arrived
	assign sum = acc + touch_pkg::acc_t'(raw.value);
	assign last_sample = frame_done && (count == touch_pkg::LAST_SAMPLE);

	// Busy is checked again here, so a late busy still holds off the frame
	assign frame_start = (state == touch_pkg::SQ_REQUEST) && !touch_busy;
	assign frame_dim = dim;

	function automatic touch_pkg::touch_dim_e next_dim(touch_pkg::touch_dim_e d);
		case (d)
			touch_pkg::DIM_X: return touch_pkg::DIM_Y;
			touch_pkg::DIM_Y: return touch_pkg::DIM_Z;
			default: return touch_pkg::DIM_X;
		endcase
	endfunction

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= touch_pkg::SQ_WAIT_BUSY;
			dim <= touch_pkg::DIM_X;
			acc <= '0;
			count <= '0;
			guard <= '0;
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= 1'b0;
			case (state)
				touch_pkg::SQ_WAIT_BUSY: begin
					// Let the port finish its gap first
					if (guard != '0) begin
						guard <= guard - 8'd1;
					end else if (!touch_busy) begin
						state <= touch_pkg::SQ_REQUEST;
					end
				end
				touch_pkg::SQ_REQUEST: begin
					if (touch_busy) begin
						state <= touch_pkg::SQ_WAIT_BUSY;
					end else begin
						state <= touch_pkg::SQ_COLLECT;
					end
				end
				touch_pkg::SQ_COLLECT: begin
					if (frame_done) begin
						state <= touch_pkg::SQ_WAIT_BUSY;
						guard <= touch_pkg::GAP_GUARD;
						count <= count + 1'b1;
						if (last_sample) begin
							// Axis complete, start the next one clean
							acc <= '0;
							avg_valid <= 1'b1;
							dim <= next_dim(dim);
						end else begin
							acc <= sum;
						end
					end
				end
				default: begin
					state <= touch_pkg::SQ_WAIT_BUSY;
				end
			endcase
		end
	end

	// Truncated mean, divide by 16 is a plain shift
	always_ff @(posedge cclk) begin
		if (last_sample) begin
			avg.dim <= dim;
			avg.value <= sum[touch_pkg::ACC_W-1:touch_pkg::AVG_SHIFT];
		end
	end

endmodule

`default_nettype wire

//--- source/touch_coord_scaler.sv
`timescale 1ns/10ps
`default_nettype none

module touch_coord_scaler (
	input wire cclk,
	input wire rstb,
	input wire avg_valid,
	input wire touch_pkg::touch_sample_t avg,
	output touch_pkg::touch_val_t x,
	output touch_pkg::touch_val_t y,
	output touch_pkg::touch_val_t z,
	output logic scan_done
);

	touch_pkg::touch_val_t x_cal;
	touch_pkg::touch_val_t y_cal;

	// Remove panel offset, floor at 0 and clamp to the usable span
	function automatic touch_pkg::touch_val_t calibrate(
		input touch_pkg::touch_val_t v,
		input touch_pkg::touch_val_t adj_min,
		input touch_pkg::touch_val_t post_max
	);
		touch_pkg::touch_val_t d;
		if (v < adj_min) begin
			return '0;
		end
		d = v - adj_min;
		if (d > post_max) begin
			return post_max;
		end
		return d;
	endfunction

	assign x_cal = calibrate(avg.value, touch_pkg::X_ADJ_MIN, touch_pkg::X_POST_ADJ_MAX);
	assign y_cal = calibrate(avg.value, touch_pkg::Y_ADJ_MIN, touch_pkg::Y_POST_ADJ_MAX);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			x <= '0;
			y <= '0;
			z <= '0;
			scan_done <= 1'b0;
		end else begin
			scan_done <= 1'b0;
			if (avg_valid) begin
				case (avg.dim)
					touch_pkg::DIM_X: x <= x_cal;
					touch_pkg::DIM_Y: y <= y_cal;
					touch_pkg::DIM_Z: begin
						// pressure is used raw, Z also closes the scan
						z <= avg.value;
						scan_done <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/touchpad_controller.sv
`timescale 1ns/10ps
`default_nettype none

module touchpad_controller (
	input wire cclk,
	input wire rstb,
	input wire touch_busy,
	input wire data_in,
	output wire touch_clk,
	output wire data_out,
	output wire touch_csb,
	output wire touch_pkg::touch_val_t x,
	output wire touch_pkg::touch_val_t y,
	output wire touch_pkg::touch_val_t z,
	output wire scan_done
);

	// Sequencer to port
	wire frame_start;
	wire touch_pkg::touch_dim_e frame_dim;
	wire frame_done;
	wire touch_pkg::touch_sample_t raw;

	// Sequencer to scaler
	wire avg_valid;
	wire touch_pkg::touch_sample_t avg;

	touch_serial_port u_port (
		.cclk(cclk),
		.rstb(rstb),
		.frame_start(frame_start),
		.frame_dim(frame_dim),
		.data_in(data_in),
		.touch_clk(touch_clk),
		.data_out(data_out),
		.touch_csb(touch_csb),
		.frame_done(frame_done),
		.raw(raw)
	);

	touch_scan_sequencer u_seq (
		.cclk(cclk),
		.rstb(rstb),
		.touch_busy(touch_busy),
		.frame_done(frame_done),
		.raw(raw),
		.frame_start(frame_start),
		.frame_dim(frame_dim),
		.avg_valid(avg_valid),
		.avg(avg)
	);

	touch_coord_scaler u_scale (
		.cclk(cclk),
		.rstb(rstb),
		.avg_valid(avg_valid),
		.avg(avg),
		.x(x),
		.y(y),
		.z(z),
		.scan_done(scan_done)
	);

endmodule

`default_nettype wire

//--- verif/touch_panel_model.sv
`timescale 1ns/10ps
`default_nettype none

// Behavioral touch converter that answers each frame from a scripted table
module touch_panel_model #(
	parameter int NUM_SCANS = 4
) (
	input wire touch_clk,
	input wire touch_csb,
	input wire cmd_bit,
	output wire resp_bit
);

	localparam int SPA = touch_pkg::SAMPLES_PER_AXIS;
	localparam int CMD_LEN = int'(touch_pkg::CMD_BITS);
	localparam int RESP_FIRST = int'(touch_pkg::RESP_START);
	localparam int RESP_LAST = RESP_FIRST + int'(touch_pkg::RESP_BITS) - 1;

	// Axis 0 is X, 1 is Y, 2 is Z
	touch_pkg::touch_val_t readings [0:2][0:NUM_SCANS-1][0:SPA-1];
	int seed = 32814;
	int cmd_errors = 0;
	int frame_no = 0;
	int rise_cnt = 0;
	logic in_frame = 1'b0;
	logic [7:0] cmd = '0;
	logic resp_q = 1'b0;

	assign resp_bit = resp_q;

	initial begin
		int r;
		for (int s = 0; s < NUM_SCANS; s++) begin
			for (int a = 0; a < 3; a++) begin
				for (int i = 0; i < SPA; i++) begin
					r = $random(seed);
					// Scan 2 stays under the panel offsets and scan 3 sits near full scale
					if (s == 1 && a == 0) begin
						readings[a][s][i] = r[11:0] % touch_pkg::X_ADJ_MIN;
					end else if (s == 1 && a == 1) begin
						readings[a][s][i] = r[11:0] % touch_pkg::Y_ADJ_MIN;
					end else if (s == 2 && a < 2) begin
						readings[a][s][i] = {8'hFF, r[3:0]};
					end else begin
						readings[a][s][i] = r[11:0];
					end
				end
			end
		end
	end

	function automatic int axis_of(int frame);
		return (frame / SPA) % 3;
	endfunction

	task automatic check_command();
		logic [1:0] want;
		logic [7:0] expected;
		want = 2'(axis_of(frame_no) + 1);
		// Fixed bits around the axis code
		expected = {4'h0, 1'b1, want, 1'b1};
		if (cmd !== expected) begin
			$display("FAILED command_framing frame %0d: expected %02h, actual %02h",
				frame_no, expected, cmd);
			cmd_errors = cmd_errors + 1;
		end
	endtask

	// Command capture takes one bit per rising edge while selected
	always @(posedge touch_clk) begin
		if (!touch_csb) begin
			if (!in_frame) begin
				in_frame = 1'b1;
				rise_cnt = 0;
			end
			if (rise_cnt < CMD_LEN) begin
				cmd = {cmd_bit, cmd[7:1]};
			end
			if (rise_cnt == CMD_LEN - 1) begin
				check_command();
			end
			rise_cnt = rise_cnt + 1;
		end else if (in_frame) begin
			in_frame = 1'b0;
			frame_no = frame_no + 1;
		end
	end

	// Response bits change after the falling edge with the MSB first
	always @(negedge touch_clk) begin : drive
		touch_pkg::touch_val_t v;
		v = readings[axis_of(frame_no)][(frame_no / (3 * SPA)) % NUM_SCANS][frame_no % SPA];
		if (!touch_csb && rise_cnt >= RESP_FIRST && rise_cnt <= RESP_LAST) begin
			v = v >> (RESP_LAST - rise_cnt);
			resp_q <= v[0];
		end else begin
			resp_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verif/touchpad_controller_checker.sv
`timescale 1ns/10ps
`default_nettype none

module touchpad_controller_checker (
	input wire cclk,
	input wire rstb,
	input wire touch_busy,
	input wire touch_clk,
	input wire data_out,
	input wire touch_csb,
	input wire touch_pkg::touch_val_t x,
	input wire scan_done
);

	// Frames in one full scan, X then Y then Z
	localparam int SCAN_FRAMES = 3 * touch_pkg::SAMPLES_PER_AXIS;

	int failures = 0;
	int frames;
	logic csb_q;

	// Chip select falls since reset
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			frames <= 0;
			csb_q <= 1'b1;
		end else begin
			csb_q <= touch_csb;
			if (csb_q && !touch_csb) begin
				frames <= frames + 1;
			end
		end
	end

	reset_pins: assert property (@(posedge cclk) !rstb |=> (touch_csb && !touch_clk))
		else begin
			$error("chip select or serial clock not idle during or just after reset");
			failures = failures + 1;
		end

	early_scan: assert property (@(posedge cclk) disable iff (!rstb)
		scan_done |-> frames >= SCAN_FRAMES)
		else begin
			$error("scan_done before a full scan of frames");
			failures = failures + 1;
		end

	done_pulse: assert property (@(posedge cclk) disable iff (!rstb) scan_done |=> !scan_done)
		else begin
			$error("scan_done held longer than one cycle");
			failures = failures + 1;
		end

	idle_data: assert property (@(posedge cclk) disable iff (!rstb)
		touch_csb && $past(touch_csb) |-> $stable(data_out))
		else begin
			$error("data_out moved while chip select was high");
			failures = failures + 1;
		end

	x_range: assert property (@(posedge cclk) disable iff (!rstb)
		x <= touch_pkg::X_POST_ADJ_MAX)
		else begin
			$error("x above its calibrated ceiling");
			failures = failures + 1;
		end

	busy_hold: assert property (@(posedge cclk) disable iff (!rstb)
		touch_busy |=> !$fell(touch_csb))
		else begin
			$error("frame started while the converter was busy");
			failures = failures + 1;
		end

endmodule

bind touchpad_controller touchpad_controller_checker chk (
	.cclk(cclk),
	.rstb(rstb),
	.touch_busy(touch_busy),
	.touch_clk(touch_clk),
	.data_out(data_out),
	.touch_csb(touch_csb),
	.x(x),
	.scan_done(scan_done)
);

`default_nettype wire

//--- verif/tb_touchpad_controller.sv
`timescale 1ns/10ps
`default_nettype none

module tb_touchpad_controller;

	localparam int NUM_SCANS = 4;
	localparam int SCAN_FRAMES = 3 * touch_pkg::SAMPLES_PER_AXIS;
	// One frame plus the sequencer gap wait, rounded up
	localparam int FRAME_CYCLES = 1300;
	localparam int BUSY_DELAY = 20000;
	localparam int BUSY_CYCLES = 5000;
	localparam int TIMEOUT_CYCLES =
		(NUM_SCANS * SCAN_FRAMES * FRAME_CYCLES + BUSY_CYCLES) * 6 / 5;

	logic cclk;
	logic rstb;
	logic touch_busy;
	wire data_in;
	wire touch_clk;
	wire data_out;
	wire touch_csb;
	wire touch_pkg::touch_val_t x;
	wire touch_pkg::touch_val_t y;
	wire touch_pkg::touch_val_t z;
	wire scan_done;
	int errors = 0;
	int cycle_count = 0;
	int scans_seen = 0;

	touchpad_controller uut (
		.cclk(cclk),
		.rstb(rstb),
		.touch_busy(touch_busy),
		.data_in(data_in),
		.touch_clk(touch_clk),
		.data_out(data_out),
		.touch_csb(touch_csb),
		.x(x),
		.y(y),
		.z(z),
		.scan_done(scan_done)
	);

	touch_panel_model #(.NUM_SCANS(NUM_SCANS)) panel (
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.cmd_bit(data_out),
		.resp_bit(data_in)
	);

	initial begin
		cclk = 1'b0;
		forever #2 cclk = ~cclk;
	end

	always @(posedge cclk) begin
		cycle_count <= cycle_count + 1;
	end

	// Truncated mean of the 16 readings the panel returns for one axis
	function automatic touch_pkg::touch_val_t axis_mean(int a, int s);
		int sum;
		sum = 0;
		for (int i = 0; i < touch_pkg::SAMPLES_PER_AXIS; i++) begin
			sum = sum + int'(panel.readings[a][s][i]);
		end
		return 12'(sum / touch_pkg::SAMPLES_PER_AXIS);
	endfunction

	function automatic touch_pkg::touch_val_t calibrated(touch_pkg::touch_val_t v,
			touch_pkg::touch_val_t lo, touch_pkg::touch_val_t hi);
		int d;
		d = int'(v) - int'(lo);
		if (d < 0) d = 0;
		if (d > int'(hi)) d = int'(hi);
		return 12'(d);
	endfunction

	function automatic string scan_name(int s);
		case (s)
			0: return "scan1_random";
			1: return "scan2_below_offset";
			2: return "scan3_full_scale";
			default: return "scan4_busy_hold";
		endcase
	endfunction

	task automatic check_value(string test, string axis, touch_pkg::touch_val_t expected,
			touch_pkg::touch_val_t actual);
		assert (actual == expected) else begin
			$display("FAILED %s %s: expected %03h, actual %03h", test, axis, expected, actual);
			errors = errors + 1;
		end
	endtask

	task automatic check_scan(int s);
		string test;
		test = scan_name(s);
		check_value(test, "x", calibrated(axis_mean(0, s), touch_pkg::X_ADJ_MIN,
			touch_pkg::X_POST_ADJ_MAX), x);
		check_value(test, "y", calibrated(axis_mean(1, s), touch_pkg::Y_ADJ_MIN,
			touch_pkg::Y_POST_ADJ_MAX), y);
		check_value(test, "z", axis_mean(2, s), z);
	endtask

	task automatic wait_scan_done();
		do begin
			@(posedge cclk);
			#1;
		end while (scan_done !== 1'b1);
	endtask

	// Converter busy in the middle of the scan
	task automatic hold_busy();
		repeat (BUSY_DELAY) @(posedge cclk);
		#1 touch_busy = 1'b1;
		repeat (BUSY_CYCLES) @(posedge cclk);
		#1 touch_busy = 1'b0;
	endtask

	task automatic print_counts();
		$display("Errors: %0d value, %0d command, %0d assertion",
			errors, panel.cmd_errors, uut.chk.failures);
	endtask

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: %0d of %0d scans finished within %0d cycles",
			scans_seen, NUM_SCANS, TIMEOUT_CYCLES);
		print_counts();
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int total;
		rstb = 1'b0;
		touch_busy = 1'b0;
		repeat (3) @(posedge cclk);
		#1 rstb = 1'b1;
		for (int s = 0; s < NUM_SCANS; s++) begin
			if (s == NUM_SCANS - 1) begin
				hold_busy();
			end
			wait_scan_done();
			check_scan(s);
			scans_seen = scans_seen + 1;
		end
		total = errors + panel.cmd_errors + uut.chk.failures;
		print_counts();
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
source/touch_pkg.sv
source/touch_serial_port.sv
source/touch_scan_sequencer.sv
source/touch_coord_scaler.sv
source/touchpad_controller.sv
verif/touch_panel_model.sv
verif/touchpad_controller_checker.sv
verif/tb_touchpad_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the touchpad controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_touchpad_controller
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -Mdir "$BUILD_DIR" -f tb.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0
